// File: common/uart_rx_defs.svh
`ifndef UART_RX_DEFS_SVH
`define UART_RX_DEFS_SVH

// sample ticks per bit
`define UART_OVERSAMPLE 32

// frame layout: start, data, parity, stop
`define UART_DATA_BITS 8
`define UART_FRAME_BITS 11

// clk cycles per sample tick, one entry per baud select
`define UART_DIV_0 5208
`define UART_DIV_1 1302
`define UART_DIV_2 326
`define UART_DIV_3 163
`define UART_DIV_4 81
`define UART_DIV_5 41
`define UART_DIV_6 27
`define UART_DIV_7 2

// word shown when either byte of a pair was bad
`define UART_ERROR_WORD 16'hFFFF

`endif

// File: common/uart_rx_pkg.sv
`default_nettype none

package uart_rx_pkg;

  // widths with a meaning of their own
  typedef logic [2:0]  baud_sel_t;
  typedef logic [12:0] divisor_t;
  typedef logic [4:0]  sample_count_t;
  typedef logic [3:0]  bit_index_t;
  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  key_t;
  typedef logic [15:0] word_t;

  // one state per field of the serial frame
  typedef enum logic [2:0] {
    idle,
    start_bit,
    data_bits,
    parity_bit,
    stop_bit
  } rx_state_t;

  // sampling controls from the frame FSM
  typedef struct packed {
    bit_index_t bit_index;
    logic       take_first;
    logic       take_check;
    logic       frame_done;
  } rx_ctrl_t;

  // one received byte with its error flags
  typedef struct packed {
    byte_t data;
    logic  parity_error;
    logic  frame_error;
  } rx_byte_t;

endpackage

`default_nettype wire

// File: uart_rx/oversample_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_defs.svh"

module oversample_timer (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       run,
  input  uart_rx_pkg::baud_sel_t     baud_select,
  output logic                       tick,
  output uart_rx_pkg::sample_count_t sample_count
);
  import uart_rx_pkg::*;

  divisor_t divisor;
  divisor_t div_count;

  // divisor lookup
  always_comb
  begin
    case (baud_select)
      3'd0:    divisor = divisor_t'(`UART_DIV_0);
      3'd1:    divisor = divisor_t'(`UART_DIV_1);
      3'd2:    divisor = divisor_t'(`UART_DIV_2);
      3'd3:    divisor = divisor_t'(`UART_DIV_3);
      3'd4:    divisor = divisor_t'(`UART_DIV_4);
      3'd5:    divisor = divisor_t'(`UART_DIV_5);
      3'd6:    divisor = divisor_t'(`UART_DIV_6);
      default: divisor = divisor_t'(`UART_DIV_7);
    endcase
  end

  // one tick on the last cycle of each divisor period
  assign tick = run && (div_count == divisor - divisor_t'(1));

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
      div_count <= '0;
    else if (!run || tick)
      div_count <= '0;
    else
      div_count <= div_count + divisor_t'(1);
  end

  // position of the tick inside the bit, wraps after 32
  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
      sample_count <= '0;
    else if (!run)
      sample_count <= '0;
    else if (tick)
    begin
      if (sample_count == sample_count_t'(`UART_OVERSAMPLE - 1))
        sample_count <= '0;
      else
        sample_count <= sample_count + sample_count_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: uart_rx/rx_frame_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frame_fsm (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       rxd_sync,
  input  logic                       tick,
  input  uart_rx_pkg::sample_count_t sample_count,
  output logic                       run,
  output uart_rx_pkg::rx_ctrl_t      ctrl
);
  import uart_rx_pkg::*;

  // frame positions: 0 start, 1 to 8 data, 9 parity, 10 stop
  localparam bit_index_t    last_data_index = 4'd8;
  localparam sample_count_t first_sample    = 5'd1;
  localparam sample_count_t last_sample     = 5'd31;

  rx_state_t  state;
  bit_index_t bit_index;
  logic       bit_end;

  assign bit_end = tick && (sample_count == last_sample);

  // the timer only runs while a frame is in progress
  assign run = (state != idle);

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      state     <= idle;
      bit_index <= '0;
    end
    else
    begin
      case (state)
        idle:
        begin
          bit_index <= '0;
          // falling edge of the start bit
          if (!rxd_sync)
            state <= start_bit;
        end
        start_bit:
        begin
          if (bit_end)
          begin
            state     <= data_bits;
            bit_index <= bit_index + bit_index_t'(1);
          end
        end
        data_bits:
        begin
          if (bit_end)
          begin
            bit_index <= bit_index + bit_index_t'(1);
            if (bit_index == last_data_index)
              state <= parity_bit;
          end
        end
        parity_bit:
        begin
          if (bit_end)
          begin
            state     <= stop_bit;
            bit_index <= bit_index + bit_index_t'(1);
          end
        end
        default:
        begin
          if (bit_end)
          begin
            state     <= idle;
            bit_index <= '0;
          end
        end
      endcase
    end
  end

  // sample controls decoded from the tick position
  always_comb
  begin
    ctrl.bit_index  = bit_index;
    ctrl.take_first = tick && (sample_count == first_sample);
    // odd counts from 3 up
    ctrl.take_check = tick && sample_count[0] && (sample_count != first_sample);
    ctrl.frame_done = bit_end && (state == stop_bit);
  end

endmodule

`default_nettype wire

// File: uart_rx/rx_deframer.sv
`timescale 1ns/1ps
`default_nettype none

module rx_deframer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  rxd,
  input  uart_rx_pkg::key_t     key,
  input  uart_rx_pkg::rx_ctrl_t ctrl,
  output logic                  rxd_sync,
  output uart_rx_pkg::rx_byte_t rx_byte,
  output logic                  byte_valid
);
  import uart_rx_pkg::*;

  logic [1:0]  sync_ff;
  logic [10:0] frame_bits;
  logic        unstable;
  logic        mismatch;
  logic        unstable_now;
  byte_t       received;

  // line idles high, so the synchronizer resets to ones
  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
      sync_ff <= 2'b11;
    else
      sync_ff <= {sync_ff[0], rxd};
  end

  assign rxd_sync = sync_ff[1];

  // first sample of each bit lands in its frame slot
  always_ff @(posedge clk)
  begin
    if (ctrl.take_first)
      frame_bits[ctrl.bit_index] <= rxd_sync;
  end

  // later samples must agree with the first one
  assign mismatch     = ctrl.take_check && (rxd_sync != frame_bits[ctrl.bit_index]);
  assign unstable_now = unstable || mismatch;

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
      unstable <= 1'b0;
    else if (ctrl.take_first && (ctrl.bit_index == '0))
      unstable <= 1'b0;
    else if (mismatch)
      unstable <= 1'b1;
  end

  assign received = frame_bits[8:1];

  // byte is formed on the last tick of the stop bit
  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      rx_byte    <= '0;
      byte_valid <= 1'b0;
    end
    else
    begin
      byte_valid <= ctrl.frame_done;
      if (ctrl.frame_done)
      begin
        // decryption wraps modulo 256
        rx_byte.data         <= received + key;
        rx_byte.parity_error <= frame_bits[9] != (^received);
        rx_byte.frame_error  <= frame_bits[0] || !frame_bits[10] || unstable_now;
      end
    end
  end

endmodule

`default_nettype wire

// File: uart_rx/word_assembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_defs.svh"

module word_assembler (
  input  logic                  clk,
  input  logic                  reset,
  input  uart_rx_pkg::rx_byte_t rx_byte,
  input  logic                  byte_valid,
  output uart_rx_pkg::word_t    word,
  output logic                  word_valid
);
  import uart_rx_pkg::*;

  logic  slot;
  logic  pair_error;
  logic  byte_error;
  byte_t high_byte;

  assign byte_error = rx_byte.parity_error || rx_byte.frame_error;

  // first byte of a pair is kept as the high half
  always_ff @(posedge clk)
  begin
    if (byte_valid && !slot)
      high_byte <= rx_byte.data;
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      slot       <= 1'b0;
      pair_error <= 1'b0;
      word       <= word_t'(`UART_ERROR_WORD);
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      if (byte_valid)
      begin
        // bad bytes still take their slot
        slot <= !slot;
        if (!slot)
          pair_error <= byte_error;
        else
        begin
          word_valid <= 1'b1;
          if (pair_error || byte_error)
            word <= word_t'(`UART_ERROR_WORD);
          else
            word <= {high_byte, rx_byte.data};
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_word_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_word_rx (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   rxd,
  input  uart_rx_pkg::baud_sel_t baud_select,
  input  uart_rx_pkg::key_t      key,
  output uart_rx_pkg::rx_byte_t  rx_byte,
  output logic                   byte_valid,
  output uart_rx_pkg::word_t     word,
  output logic                   word_valid
);
  import uart_rx_pkg::*;

  logic          run;
  logic          tick;
  logic          rxd_sync;
  sample_count_t sample_count;
  rx_ctrl_t      ctrl;

  oversample_timer u_oversample_timer (
    .clk          (clk),
    .reset        (reset),
    .run          (run),
    .baud_select  (baud_select),
    .tick         (tick),
    .sample_count (sample_count)
  );

  rx_frame_fsm u_rx_frame_fsm (
    .clk          (clk),
    .reset        (reset),
    .rxd_sync     (rxd_sync),
    .tick         (tick),
    .sample_count (sample_count),
    .run          (run),
    .ctrl         (ctrl)
  );

  rx_deframer u_rx_deframer (
    .clk        (clk),
    .reset      (reset),
    .rxd        (rxd),
    .key        (key),
    .ctrl       (ctrl),
    .rxd_sync   (rxd_sync),
    .rx_byte    (rx_byte),
    .byte_valid (byte_valid)
  );

  // byte pairs into words
  word_assembler u_word_assembler (
    .clk        (clk),
    .reset      (reset),
    .rx_byte    (rx_byte),
    .byte_valid (byte_valid),
    .word       (word),
    .word_valid (word_valid)
  );

endmodule

`default_nettype wire

// File: test/uart_rx_properties.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_properties (
  input logic clk,
  input logic reset,
  input logic byte_valid,
  input logic word_valid
);

  // valid strobes are single-cycle pulses
  byte_valid_pulse: assert property (@(posedge clk) disable iff (!reset)
    byte_valid |=> !byte_valid)
    else $error("byte_valid stayed high for more than one cycle");

  word_valid_pulse: assert property (@(posedge clk) disable iff (!reset)
    word_valid |=> !word_valid)
    else $error("word_valid stayed high for more than one cycle");

  // a word always follows its second byte by one cycle
  word_after_byte: assert property (@(posedge clk) disable iff (!reset)
    word_valid |-> $past(byte_valid))
    else $error("word_valid without byte_valid in the previous cycle");

  quiet_in_reset: assert property (@(posedge clk)
    !reset |-> (!byte_valid && !word_valid))
    else $error("valid signal high while reset is asserted");

endmodule

bind uart_word_rx uart_rx_properties u_uart_rx_properties (
  .clk        (clk),
  .reset      (reset),
  .byte_valid (byte_valid),
  .word_valid (word_valid)
);

`default_nettype wire

// File: test/tb_uart_word_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_rx_defs.svh"

module tb_uart_word_rx;
  import uart_rx_pkg::*;

  localparam int num_lines    = 10;
  localparam int num_fields   = 8;
  localparam int max_gap      = 40;
  localparam int glitch_index = 4;

  logic      clk;
  logic      reset;
  logic      rxd;
  baud_sel_t baud_select;
  key_t      key;
  rx_byte_t  rx_byte;
  logic      byte_valid;
  word_t     word;
  logic      word_valid;

  logic [15:0] stim_mem [0:num_lines*num_fields-1];
  int          cycle_count = 0;
  int          timeout_limit;
  int unsigned seed_value;

  uart_word_rx u_uart_word_rx (
    .clk         (clk),
    .reset       (reset),
    .rxd         (rxd),
    .baud_select (baud_select),
    .key         (key),
    .rx_byte     (rx_byte),
    .byte_valid  (byte_valid),
    .word        (word),
    .word_valid  (word_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_limit)
    begin
      $display("timeout: no result from the receiver after %0d clock cycles", cycle_count);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  function automatic int divisor_for(input baud_sel_t sel);
    case (sel)
      3'd0:    return `UART_DIV_0;
      3'd1:    return `UART_DIV_1;
      3'd2:    return `UART_DIV_2;
      3'd3:    return `UART_DIV_3;
      3'd4:    return `UART_DIV_4;
      3'd5:    return `UART_DIV_5;
      3'd6:    return `UART_DIV_6;
      default: return `UART_DIV_7;
    endcase
  endfunction

  function automatic logic [15:0] stim_field(input int line, input int index);
    logic [6:0] addr;
    addr = 7'(line * num_fields + index);
    return stim_mem[addr];
  endfunction

  // two frames and two maximum gaps per line, plus 10 %
  function automatic int timeout_cycles();
    int total;
    int bit_times;
    int i;
    total     = 100;
    bit_times = 2 * `UART_FRAME_BITS + 2 * max_gap;
    for (i = 0; i < num_lines; i++)
      total = total + bit_times * `UART_OVERSAMPLE * divisor_for(baud_sel_t'(stim_field(i, 0)));
    return total + total / 10;
  endfunction

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected)
    begin
      $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic hold_line(input logic level, input int cycles);
    rxd <= level;
    repeat (cycles) @(posedge clk);
  endtask

  task automatic send_frame(input byte_t data, input int div, input bit flip_parity,
                            input bit stop_low, input bit glitch);
    logic [10:0] bits;
    int          len;
    int          lead;
    int          i;
    // stop, even parity, data LSB first, start
    bits = {!stop_low, (^data) ^ flip_parity, data, 1'b0};
    lead = (`UART_OVERSAMPLE / 2 - 2) * div;
    @(posedge clk);
    for (i = 0; i < `UART_FRAME_BITS; i++)
    begin
      len = `UART_OVERSAMPLE * div;
      // receiver bit timing begins one clk after it sees the edge
      if (i == 0)
        len = len + 1;
      if (glitch && (i == glitch_index))
      begin
        hold_line(bits[0], lead);
        hold_line(!bits[0], 4 * div);
        hold_line(bits[0], lead);
      end
      else
        hold_line(bits[0], len);
      bits = bits >> 1;
    end
    rxd <= 1'b1;
  endtask

  task automatic idle_gap(input int div);
    int gap_bits;
    gap_bits = 1 + int'($urandom % max_gap);
    @(posedge clk);
    hold_line(1'b1, gap_bits * `UART_OVERSAMPLE * div);
  endtask

  // no word may appear while a byte is still on its way
  task automatic wait_for_byte();
    @(negedge clk);
    while (!byte_valid)
    begin
      check_value("word_valid", 16'(word_valid), 16'h0000);
      @(negedge clk);
    end
  endtask

  task automatic wait_for_word();
    @(negedge clk);
    while (!word_valid)
      @(negedge clk);
  endtask

  task automatic send_word_pair(input int line);
    baud_sel_t   sel;
    key_t        line_key;
    byte_t       high_plain;
    byte_t       low_plain;
    logic [15:0] inject;
    int          div;
    sel        = baud_sel_t'(stim_field(line, 0));
    line_key   = key_t'(stim_field(line, 1));
    high_plain = byte_t'(stim_field(line, 2));
    low_plain  = byte_t'(stim_field(line, 3));
    inject     = stim_field(line, 4);
    div        = divisor_for(sel);
    @(posedge clk);
    baud_select <= sel;
    key         <= line_key;

    // bytes go out encrypted, the receiver adds the key back
    send_frame(high_plain - line_key, div, inject == 16'd1, 1'b0, inject == 16'd3);
    wait_for_byte();
    check_value("rx_byte.data", 16'(rx_byte.data), 16'(high_plain));
    check_value("rx_byte flags", 16'({rx_byte.parity_error, rx_byte.frame_error}),
                stim_field(line, 6));
    // the first byte of a pair gives no word
    @(negedge clk);
    check_value("word_valid", 16'(word_valid), 16'h0000);
    idle_gap(div);

    send_frame(low_plain - line_key, div, 1'b0, inject == 16'd2, 1'b0);
    wait_for_byte();
    check_value("rx_byte.data", 16'(rx_byte.data), 16'(low_plain));
    check_value("rx_byte flags", 16'({rx_byte.parity_error, rx_byte.frame_error}),
                stim_field(line, 7));
    wait_for_word();
    check_value("word", word, stim_field(line, 5));
    idle_gap(div);
  endtask

  initial
  begin
    int line_idx;
    rxd         <= 1'b1;
    reset       <= 1'b0;
    baud_select <= '0;
    key         <= '0;
    seed_value = $urandom(24362);
    $readmemh("test/uart_rx_stimulus.txt", stim_mem);
    timeout_limit = timeout_cycles();

    repeat (10) @(posedge clk);
    reset <= 1'b1;
    @(negedge clk);
    check_value("word", word, 16'(`UART_ERROR_WORD));
    check_value("byte_valid", 16'(byte_valid), 16'h0000);
    check_value("word_valid", 16'(word_valid), 16'h0000);

    for (line_idx = 0; line_idx < num_lines; line_idx++)
      send_word_pair(line_idx);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/uart_rx_stimulus.txt
// columns: baud_select key high_byte low_byte inject expected_word high_flags low_flags
// inject 0 none, 1 parity flip high, 2 stop low on low, 3 glitch in high; flags {parity,frame}
7 00 12 34 0 1234 0 0
7 5a a5 3c 0 a53c 0 0
6 c3 de ad 0 dead 0 0
7 01 ff 00 0 ff00 0 0
7 80 55 aa 1 ffff 2 0
7 37 0f f0 0 0ff0 0 0
6 e4 9b 62 2 ffff 0 1
7 19 71 c8 3 ffff 1 0
6 7e be ef 0 beef 0 0
7 ff 00 01 0 0001 0 0

// File: compile.f
+incdir+common
common/uart_rx_pkg.sv
uart_rx/oversample_timer.sv
uart_rx/rx_frame_fsm.sv
uart_rx/rx_deframer.sv
uart_rx/word_assembler.sv
rtl/uart_word_rx.sv
test/uart_rx_properties.sv
test/tb_uart_word_rx.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f \
  --top-module tb_uart_word_rx -o sim_uart_word_rx

./obj_dir/sim_uart_word_rx > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
